// ==== compile.f ====
hw/cache_dir_pkg.sv
hw/cache_regfile_sp.sv
hw/cache_flush_counter.sv
hw/cache_tag_store.sv
hw/cache_replacement_policy.sv
hw/cache_dir_ctrl.sv
hw/cache_directory.sv
bench/cache_directory_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cache_directory_tb
RTL_TOP    := cache_directory
FILELIST   := compile.f
REP_POLICY ?= 1
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := all tests passed
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -GREP_POLICY=$(REP_POLICY) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/cache_directory_tb.sv ====
`timescale 1ns/1ps

module cache_directory_tb import cache_dir_pkg::*; #(
   parameter int REP_POLICY = REP_PLRU_TREE
);

   localparam int N_WAYS  = 4;
   localparam int NWAYS_W = 2;
   localparam int NLINES  = 2**LINE_W;
   localparam int N_RAND  = 400;
   // about 3 cycles per lookup plus the sweep and reset
   localparam int EST_CYCLES =
      3 * (NLINES + 3 * N_WAYS + 1 + N_RAND + NLINES * N_WAYS) + NLINES + 20;
   localparam int MAX_CYCLES = 2 * EST_CYCLES;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        req;
   lookup_req_t req_data;
   logic        flush;
   logic        rsp_valid;
   lookup_rsp_t rsp_data;
   logic        busy;

   logic [TAG_W-1:0]  m_tag   [NLINES][N_WAYS];  // model tag array
   logic              m_valid [NLINES][N_WAYS];
   int                m_age   [NLINES][N_WAYS];  // lru ages where 0 is oldest
   logic [N_WAYS-1:1] m_tree  [NLINES];          // plru nodes with the root at 1

   int    seed = 32'h741a_ab3a;
   int    cycles = 0;
   int    errors = 0;
   int    checks;
   int    test_errs;
   int    n_tests = 0;
   int    n_fail = 0;
   string test_name;

   cache_directory #(.REP_POLICY(REP_POLICY)) dut0 (
      .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .req_data_i(req_data), .flush_i(flush),
      .rsp_valid_o(rsp_valid), .rsp_data_o(rsp_data), .busy_o(busy)
   );

   always #5 clk = ~clk;  // 10 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   task automatic clear_model();
      for (int l = 0; l < NLINES; l++) begin
         m_tree[l] = '0;  // all nodes point left
         for (int w = 0; w < N_WAYS; w++) begin
            m_valid[l][w] = 1'b0;
            m_age[l][w]   = w;  // fresh line starts with age equal to way index
         end
      end
   endtask

   function automatic int predict_victim(input int l);
      int node;
      node = 1;
      if (REP_POLICY == REP_LRU) begin
         for (int w = 0; w < N_WAYS; w++) begin
            if (m_age[l][w] == 0)
               return w;
         end
         return 0;
      end
      while (node < N_WAYS)
         node = m_tree[l][node] ? 2 * node + 1 : 2 * node;  // node 0 goes left and 1 right
      return node - N_WAYS;
   endfunction

   task automatic touch_line(input int l, input int way);
      int old;
      int node;
      old  = m_age[l][way];
      node = 1;
      if (REP_POLICY == REP_LRU) begin
         for (int w = 0; w < N_WAYS; w++) begin
            if (w == way)
               m_age[l][w] = N_WAYS - 1;  // most recent
            else if (m_age[l][w] > old)
               m_age[l][w] = m_age[l][w] - 1;
         end
      end else begin
         // walk down from the root along the way bits from the msb
         for (int b = NWAYS_W - 1; b >= 0; b--) begin
            m_tree[l][node] = ~way[b];  // point at the other half
            node = 2 * node + int'(way[b]);
         end
      end
   endtask

   task automatic predict_access(input int l, input logic [TAG_W-1:0] tg,
                                 output lookup_rsp_t exp);
      int way;
      way = -1;
      for (int w = 0; w < N_WAYS; w++) begin
         if (m_valid[l][w] && m_tag[l][w] == tg)
            way = w;
      end
      exp.hit  = (way >= 0);
      exp.fill = (way < 0);
      if (way < 0) begin
         way = predict_victim(l);  // policy victim even if a way is invalid
         m_tag[l][way]   = tg;
         m_valid[l][way] = 1'b1;
      end
      exp.way = WAY_W'(way);
      touch_line(l, way);
   endtask

   task automatic compare_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_errs++;
      end
   endtask

   // one strobe and a wait for the response pulse
   task automatic lookup(input int l, input logic [TAG_W-1:0] tg, output lookup_rsp_t got);
      lookup_rsp_t exp;
      int          wait_cnt;
      predict_access(l, tg, exp);
      @(posedge clk);
      req      <= 1'b1;
      req_data <= {tg, LINE_W'(l)};
      @(posedge clk);
      req      <= 1'b0;
      wait_cnt = 0;
      @(negedge clk);  // sample away from the edge
      while (!rsp_valid && wait_cnt < 4) begin
         @(negedge clk);
         wait_cnt++;
      end
      got = rsp_data;
      if (!rsp_valid) begin
         $display("%s: no response to the lookup of line %0d tag %h", test_name, l, tg);
         test_errs++;
      end else begin
         compare_value("latency", 0, wait_cnt);  // response in the cycle after the strobe
         compare_value("busy in response", 1, 32'(busy));
         compare_value("response", 32'(exp), 32'(got));
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      checks    = 0;
      test_errs = 0;
   endtask

   task automatic end_test();
      n_tests++;
      errors += test_errs;
      if (test_errs == 0) begin
         $display("test %s: pass, %0d checks", test_name, checks);
      end else begin
         n_fail++;
         $display("test %s: FAIL, %0d errors in %0d checks", test_name, test_errs, checks);
      end
   endtask

   initial begin
      lookup_rsp_t      got;
      logic [TAG_W-1:0] evicted;
      logic [TAG_W-1:0] old_tag   [NLINES][N_WAYS];  // model contents before the flush
      logic             old_valid [NLINES][N_WAYS];
      int               busy_cycles;
      int               r;
      rst_n    = 1'b0;
      req      = 1'b0;
      req_data = '0;
      flush    = 1'b0;
      clear_model();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      begin_test("reset_miss");
      @(negedge clk);
      compare_value("busy", 0, 32'(busy));
      compare_value("rsp_valid", 0, 32'(rsp_valid));
      for (int l = 0; l < NLINES; l++) begin
         lookup(l, TAG_W'(8'hA0 + l), got);
         compare_value("hit and fill", 1, 32'({got.hit, got.fill}));
      end
      end_test();

      begin_test("fill_repeat");
      for (int i = 0; i < 2 * N_WAYS; i++) begin
         lookup(2, TAG_W'(8'h10 + i % N_WAYS), got);
         if (i >= N_WAYS)
            compare_value("repeat hit", 1, 32'(got.hit));
      end
      end_test();

      begin_test("evict");
      evicted = m_tag[2][predict_victim(2)];  // tag the model expects to lose
      lookup(2, TAG_W'(8'h14), got);
      for (int i = 0; i < N_WAYS; i++) begin
         if (TAG_W'(8'h10 + i) != evicted) begin
            lookup(2, TAG_W'(8'h10 + i), got);
            compare_value("kept tag hit", 1, 32'(got.hit));
         end
      end
      lookup(2, evicted, got);
      compare_value("evicted tag miss", 0, 32'(got.hit));
      end_test();

      begin_test("random");
      for (int i = 0; i < N_RAND; i++) begin
         r = $random(seed);
         lookup(r & (NLINES - 1), TAG_W'(8'h40 + ((r >> 4) & 15) % 6), got);  // pool of 6
      end
      end_test();

      begin_test("flush");
      old_tag   = m_tag;
      old_valid = m_valid;
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      busy_cycles = 0;
      @(negedge clk);
      while (busy && busy_cycles <= 2 * NLINES) begin
         busy_cycles++;
         @(negedge clk);
      end
      clear_model();
      compare_value("busy cycles", NLINES, busy_cycles);
      for (int l = 0; l < NLINES; l++) begin
         for (int w = 0; w < N_WAYS; w++) begin
            if (old_valid[l][w]) begin
               lookup(l, old_tag[l][w], got);  // victim order from reset state
               compare_value("miss after flush", 0, 32'(got.hit));
            end
         end
      end
      end_test();

      $display("summary: %0d tests run, %0d passed, %0d failed, %0d errors",
               n_tests, n_tests - n_fail, n_fail, errors);
      if (n_fail == 0 && errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== hw/cache_directory.sv ====
`timescale 1ns/1ps

module cache_directory import cache_dir_pkg::*; #(
   parameter int N_WAYS     = 4,
   parameter int NWAYS_W    = $clog2(N_WAYS),
   parameter int NLINES_W   = cache_dir_pkg::LINE_W,
   parameter int TAG_W      = cache_dir_pkg::TAG_W,
   parameter int REP_POLICY = REP_PLRU_TREE
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        req_i,
   input  lookup_req_t req_data_i,
   input  logic        flush_i,
   output logic        rsp_valid_o,
   output lookup_rsp_t rsp_data_o,
   output logic        busy_o
);

   lookup_req_t         req_q;
   logic                flush_start, flush_run, flush_last;
   logic [NLINES_W-1:0] flush_line;
   logic [NLINES_W-1:0] pol_line;  // policy row address
   logic                pol_we, fill_we;
   logic [N_WAYS-1:0]   way_hit, victim, access_way;
   logic [NWAYS_W-1:0]  victim_bin;

   assign pol_line = flush_run ? flush_line : NLINES_W'(req_q.line);

   cache_dir_ctrl #(.N_WAYS(N_WAYS), .NWAYS_W(NWAYS_W)) ctrl0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req_i), .req_data_i(req_data_i),
      .flush_i(flush_i), .flush_last_i(flush_last), .way_hit_i(way_hit),
      .victim_i(victim), .victim_bin_i(victim_bin), .req_q_o(req_q),
      .flush_start_o(flush_start), .flush_run_o(flush_run), .pol_we_o(pol_we),
      .fill_we_o(fill_we), .access_way_o(access_way), .rsp_valid_o(rsp_valid_o),
      .rsp_data_o(rsp_data_o), .busy_o(busy_o)
   );

   cache_flush_counter #(.NLINES_W(NLINES_W)) flush_cnt0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(flush_start), .run_i(flush_run),
      .line_o(flush_line), .last_o(flush_last)
   );

   cache_tag_store #(.N_WAYS(N_WAYS), .NLINES_W(NLINES_W), .TAG_W(TAG_W)) tags0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req_q), .fill_we_i(fill_we),
      .fill_way_i(access_way), .clr_i(flush_run), .clr_line_i(flush_line),
      .way_hit_o(way_hit)
   );

   cache_replacement_policy #(
      .N_WAYS(N_WAYS), .NWAYS_W(NWAYS_W), .NLINES_W(NLINES_W), .REP_POLICY(REP_POLICY)
   ) rep0 (
      .clk_i(clk_i), .rst_n_i(rst_n_i), .write_en_i(pol_we), .clr_i(flush_run),
      .way_hit_i(access_way), .line_addr_i(pol_line), .way_select_o(victim),
      .way_select_bin_o(victim_bin)
   );

endmodule

// ==== hw/cache_dir_ctrl.sv ====
`timescale 1ns/1ps

module cache_dir_ctrl import cache_dir_pkg::*; #(
   parameter int N_WAYS  = 4,
   parameter int NWAYS_W = $clog2(N_WAYS)
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               req_i,
   input  lookup_req_t        req_data_i,
   input  logic               flush_i,
   input  logic               flush_last_i,
   input  logic [N_WAYS-1:0]  way_hit_i,
   input  logic [N_WAYS-1:0]  victim_i,
   input  logic [NWAYS_W-1:0] victim_bin_i,
   output lookup_req_t        req_q_o,        // request held for the lookup cycle
   output logic               flush_start_o,
   output logic               flush_run_o,    // also the clear for both stores
   output logic               pol_we_o,
   output logic               fill_we_o,
   output logic [N_WAYS-1:0]  access_way_o,   // way touched by this lookup
   output logic               rsp_valid_o,
   output lookup_rsp_t        rsp_data_o,
   output logic               busy_o
);

   typedef enum logic [1:0] {IDLE, LOOKUP, FLUSH} state_t;

   state_t             state_q, state_d;
   logic               hit;
   logic [NWAYS_W-1:0] hit_bin;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) state_q <= IDLE;
      else          state_q <= state_d;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (flush_i)    state_d = FLUSH;   // flush wins over a lookup
            else if (req_i) state_d = LOOKUP;
         end
         LOOKUP: state_d = IDLE;               // single response cycle
         FLUSH: begin
            if (flush_last_i) state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   // request capture, payload only
   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && req_i) req_q_o <= req_data_i;
   end

   assign hit     = |way_hit_i;
   assign hit_bin = NWAYS_W'(onehot_to_bin(32'(way_hit_i)));

   assign flush_start_o = (state_q == IDLE) & flush_i;
   assign flush_run_o   = (state_q == FLUSH);

   // on a miss the victim is both the fill target and the accessed way
   assign access_way_o = hit ? way_hit_i : victim_i;
   assign pol_we_o     = (state_q == LOOKUP);
   assign fill_we_o    = (state_q == LOOKUP) & ~hit;

   assign rsp_valid_o     = (state_q == LOOKUP);
   assign rsp_data_o.hit  = hit;
   assign rsp_data_o.way  = WAY_W'(hit ? hit_bin : victim_bin_i);
   assign rsp_data_o.fill = ~hit;
   assign busy_o          = (state_q != IDLE);

endmodule

// ==== hw/cache_replacement_policy.sv ====
`timescale 1ns/1ps

module cache_replacement_policy import cache_dir_pkg::*; #(
   parameter int N_WAYS     = 4,
   parameter int NWAYS_W    = $clog2(N_WAYS),
   parameter int NLINES_W   = 3,
   parameter int REP_POLICY = REP_PLRU_TREE
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                write_en_i,        // update row with access vector
   input  logic                clr_i,             // flush, zero the row
   input  logic [N_WAYS-1:0]   way_hit_i,         // accessed way, one-hot
   input  logic [NLINES_W-1:0] line_addr_i,
   output logic [N_WAYS-1:0]   way_select_o,      // victim, one-hot
   output logic [NWAYS_W-1:0]  way_select_bin_o   // victim, binary
);

   if (REP_POLICY == REP_LRU) begin : g_lru
      // row holds one age per way, highest age is most recently used
      localparam int ROW_W = N_WAYS * NWAYS_W;

      logic [ROW_W-1:0]   row_q, row_d;
      logic [NWAYS_W-1:0] age [N_WAYS];  // decoded ages
      logic [NWAYS_W-1:0] hit_bin;
      logic [NWAYS_W-1:0] hit_age;       // old age of accessed way

      assign hit_bin = NWAYS_W'(onehot_to_bin(32'(way_hit_i)));
      assign hit_age = age[hit_bin];

      for (genvar w = 0; w < N_WAYS; w++) begin : g_age
         // an all-zero row is a fresh line, ages start at the way index
         assign age[w] = (|row_q) ? row_q[w*NWAYS_W +: NWAYS_W] : NWAYS_W'(w);

         // accessed way goes to the top, younger ways above it slide down one
         assign row_d[w*NWAYS_W +: NWAYS_W] =
            way_hit_i[w]       ? {NWAYS_W{1'b1}} :
            (age[w] > hit_age) ? age[w] - 1'b1   :
                                 age[w];

         assign way_select_o[w] = (age[w] == '0);  // oldest way is the victim
      end

      assign way_select_bin_o = NWAYS_W'(onehot_to_bin(32'(way_select_o)));

      cache_regfile_sp #(
         .ADDR_W(NLINES_W),
         .DATA_W(ROW_W)
      ) age_mem (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .we_i    (write_en_i | clr_i),
         .clr_i   (clr_i),
         .addr_i  (line_addr_i),
         .w_data_i(row_d),
         .r_data_o(row_q)
      );

   end else begin : g_plru_tree
      // heap numbering, node 1 is the root, node n has children 2n and 2n+1
      // leaves N_WAYS..2*N_WAYS-1 map to ways 0..N_WAYS-1
      // node bit 0 points left, 1 points right
      logic [N_WAYS-1:1]  tree_q, tree_d;
      logic [NWAYS_W-1:0] acc_bin;

      assign acc_bin = NWAYS_W'(onehot_to_bin(32'(way_hit_i)));

      always_comb begin : victim_walk
         int node;
         node = 1;
         for (int l = 0; l < NWAYS_W; l++) begin
            node = 2 * node + int'(tree_q[node]);  // follow the pointer down
         end
         way_select_bin_o = NWAYS_W'(node - N_WAYS);
      end

      assign way_select_o = N_WAYS'(1) << way_select_bin_o;

      always_comb begin : path_update
         int node;
         tree_d = tree_q;
         node   = N_WAYS + int'(acc_bin);  // leaf of accessed way
         for (int l = 0; l < NWAYS_W; l++) begin
            tree_d[node / 2] = ~node[0];  // came from the left, so point right
            node = node / 2;
         end
      end

      cache_regfile_sp #(
         .ADDR_W(NLINES_W),
         .DATA_W(N_WAYS - 1)
      ) tree_mem (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .we_i    (write_en_i | clr_i),
         .clr_i   (clr_i),
         .addr_i  (line_addr_i),
         .w_data_i(tree_d),
         .r_data_o(tree_q)
      );
   end

endmodule

// ==== hw/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store import cache_dir_pkg::*; #(
   parameter int N_WAYS   = 4,
   parameter int NLINES_W = 3,
   parameter int TAG_W    = 8
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  lookup_req_t         req_i,       // registered lookup
   input  logic                fill_we_i,   // miss, write tag into selected way
   input  logic [N_WAYS-1:0]   fill_way_i,  // one-hot
   input  logic                clr_i,       // flush sweep active
   input  logic [NLINES_W-1:0] clr_line_i,  // sweep line
   output logic [N_WAYS-1:0]   way_hit_o
);

   logic [NLINES_W-1:0] line;
   logic [TAG_W-1:0]    req_tag;

   assign line    = clr_i ? clr_line_i : NLINES_W'(req_i.line);  // sweep owns the address
   assign req_tag = TAG_W'(req_i.tag);

   for (genvar w = 0; w < N_WAYS; w++) begin : g_way
      logic [TAG_W-1:0] tag_q;
      logic             valid_q;
      logic             fill;

      assign fill = fill_we_i & fill_way_i[w];

      cache_regfile_sp #(
         .ADDR_W(NLINES_W),
         .DATA_W(TAG_W)
      ) tag_mem (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .we_i    (fill),
         .clr_i   (1'b0),  // tags are never cleared, valid bit guards them
         .addr_i  (line),
         .w_data_i(req_tag),
         .r_data_o(tag_q)
      );

      cache_regfile_sp #(
         .ADDR_W(NLINES_W),
         .DATA_W(1)
      ) valid_mem (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .we_i    (fill | clr_i),
         .clr_i   (clr_i),
         .addr_i  (line),
         .w_data_i(1'b1),  // fill marks valid
         .r_data_o(valid_q)
      );

      assign way_hit_o[w] = valid_q & (tag_q == req_tag);
   end

endmodule

// ==== hw/cache_flush_counter.sv ====
`timescale 1ns/1ps

module cache_flush_counter #(
   parameter int NLINES_W = 3
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                start_i,  // load line zero
   input  logic                run_i,    // step one line per cycle
   output logic [NLINES_W-1:0] line_o,
   output logic                last_o
);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         line_o <= '0;
      end else if (start_i) begin
         line_o <= '0;
      end else if (run_i) begin
         line_o <= line_o + 1'b1;  // wraps back to zero after the last line
      end
   end

   assign last_o = &line_o;  // final line of the sweep

endmodule

// ==== hw/cache_regfile_sp.sv ====
`timescale 1ns/1ps

module cache_regfile_sp #(
   parameter int ADDR_W = 3,
   parameter int DATA_W = 8
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              we_i,
   input  logic              clr_i,     // store zeros instead of w_data_i
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   output logic [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];  // one row per line

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] <= '0;  // whole array comes up empty
         end
      end else if (we_i) begin
         mem[addr_i] <= clr_i ? '0 : w_data_i;
      end
   end

   // read is combinational, same cycle as the address
   assign r_data_o = mem[addr_i];

endmodule

// ==== hw/cache_dir_pkg.sv ====
package cache_dir_pkg;

   // replacement policy select codes
   localparam int REP_LRU       = 0;  // per-way age counters
   localparam int REP_PLRU_TREE = 1;  // binary tree of direction bits

   // field widths of the lookup words, top-level defaults follow these
   localparam int TAG_W  = 8;
   localparam int LINE_W = 3;
   localparam int WAY_W  = 2;  // way number field, sized for the default 4 ways

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [LINE_W-1:0] line;  // set index
   } lookup_req_t;

   typedef struct packed {
      logic             hit;
      logic [WAY_W-1:0] way;   // hit way, or victim way on a miss
      logic             fill;  // tag was written into way
   } lookup_rsp_t;

   // one-hot to binary, OR of the indices of all set bits
   function automatic int unsigned onehot_to_bin(input logic [31:0] onehot);
      int unsigned bin;
      bin = 0;
      for (int i = 0; i < 32; i++) begin
         if (onehot[i]) begin
            bin = bin | unsigned'(i);
         end
      end
      return bin;
   endfunction

endpackage
